//--- files.f
+incdir+include
logic/cache_pkg.sv
logic/tagArray.sv
logic/dataArray.sv
logic/lruTable.sv
logic/cacheCtrlFsm.sv
logic/l2CacheTop.sv
testbench/tbClock.sv
testbench/cacheChecker.sv
testbench/cacheTb.sv

//--- include/cache_config.svh
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// cache geometry
`define CACHE_WAYS      2       // victim choice in the FSM assumes two ways
`define CACHE_INDEX_W   6       // 64 sets
`define CACHE_OFFSET_W  2       // byte offset inside the word

// bus widths
`define CACHE_ADDR_W    32
`define CACHE_DATA_W    32
`define CACHE_STRB_W    (`CACHE_DATA_W / 8)

// what is left of the address after index and offset, 24 bits
`define CACHE_TAG_W     (`CACHE_ADDR_W - `CACHE_INDEX_W - `CACHE_OFFSET_W)

`endif

//--- logic/cacheCtrlFsm.sv
`timescale 1ns/1ps
`default_nettype none
`include "cache_config.svh"

// write-through cache without write allocate
module cacheCtrlFsm (
    input  wire                         clk,
    input  wire                         rstn,

    // pipeline side
    input  wire                         reqValid,
    output logic                        reqReady,
    input  wire cache_pkg::cpuReq_t     req,
    output logic                        respValid,
    output cache_pkg::cpuResp_t         resp,

    // memory side
    output logic                        memReqValid,
    output cache_pkg::memReq_t          memReq,
    input  wire                         memAddrOk,   // request taken
    input  wire                         memDataOk,   // read word valid
    input  wire [`CACHE_DATA_W-1:0]     memRdata,

    // arrays
    output cache_pkg::lineSel_t         lookup,
    input  wire [`CACHE_WAYS-1:0]       wayHit,
    input  wire [`CACHE_DATA_W-1:0]     readWord,
    output logic [`CACHE_WAYS-1:0]      wayWe,
    output logic                        refill,
    output logic [`CACHE_DATA_W-1:0]    refillData,
    output logic                        useValid,
    output logic                        useWay,
    input  wire                         victimWay
);

    typedef enum logic [2:0] {
        Idle,
        Lookup,
        ReadReq,       // read miss holds memReqValid until addrOK
        ReadWait,      // waiting on dataOK
        WriteMem       // every store goes to memory
    } fsmState_t;

    fsmState_t state;
    fsmState_t nextState;

    cache_pkg::cpuReq_t reqBuf;   // the one request in flight

    logic isHit;
    logic hitWay;

    //////////////////////////////////////////////////
    // request buffer
    //////////////////////////////////////////////////

    // loaded on every accepted request
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            reqBuf <= '0;
        end else if (reqValid && reqReady) begin
            reqBuf <= req;
        end
    end

    // arrays look at the buffered address and not the live request
    assign lookup.index = reqBuf.addr[`CACHE_OFFSET_W +: `CACHE_INDEX_W];
    assign lookup.tag   = reqBuf.addr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
    assign lookup.wstrb = reqBuf.wstrb;

    assign isHit  = |wayHit;
    assign hitWay = wayHit[1];    // way 0 unless way 1 hits

    //////////////////////////////////////////////////
    // memory request
    //////////////////////////////////////////////////

    // all fields come from the buffer and hold through back-pressure
    assign memReqValid   = (state == ReadReq) || (state == WriteMem);
    assign memReq.addr   = reqBuf.addr;
    assign memReq.wdata  = reqBuf.wdata;
    assign memReq.wstrb  = reqBuf.isWrite ? reqBuf.wstrb : '0;
    assign memReq.wr     = reqBuf.isWrite;

    assign refillData = memRdata;   // refill word is the one forwarded

    //////////////////////////////////////////////////
    // state register
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= Idle;
        end else begin
            state <= nextState;
        end
    end

    //////////////////////////////////////////////////
    // next state and strobes
    //////////////////////////////////////////////////

    always_comb begin
        nextState    = state;
        reqReady     = 1'b0;
        respValid    = 1'b0;
        resp.rdata   = readWord;
        resp.isWrite = reqBuf.isWrite;
        wayWe        = '0;
        refill       = 1'b0;
        useValid     = 1'b0;
        useWay       = hitWay;

        unique case (state)
            Idle: begin
                reqReady = 1'b1;
            end

            Lookup: begin
                if (reqBuf.isWrite) begin
                    // merge into the hitting way only
                    wayWe     = wayHit;
                    useValid  = isHit;
                    nextState = WriteMem;
                end else if (isHit) begin
                    respValid = 1'b1;   // read hit answers right away
                    useValid  = 1'b1;
                    reqReady  = 1'b1;   // so hits can stream
                end else begin
                    nextState = ReadReq;
                end
            end

            ReadReq: begin
                if (memAddrOk) begin
                    nextState = ReadWait;
                end
            end

            ReadWait: begin
                if (memDataOk) begin
                    // forward, refill and take the next request in one cycle
                    respValid        = 1'b1;
                    resp.rdata       = memRdata;
                    refill           = 1'b1;
                    wayWe[victimWay] = 1'b1;
                    useValid         = 1'b1;
                    useWay           = victimWay;
                    reqReady         = 1'b1;
                end
            end

            WriteMem: begin
                if (memAddrOk) begin
                    respValid = 1'b1;   // store done once memory takes it
                    reqReady  = 1'b1;
                end
            end

            default: begin
                nextState = Idle;
            end
        endcase

        // a free FSM either takes the next request or goes idle
        if (reqReady) begin
            nextState = reqValid ? Lookup : Idle;
        end
    end

    //////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////

    // memory may stall the request but must not see it change
    property memReqHeld;
        @(posedge clk) disable iff (!rstn)
            memReqValid && !memAddrOk |=> memReqValid && $stable(memReq);
    endproperty
    memReqHeldA: assert property (memReqHeld);

    // after a response nothing more comes back until a new request is taken
    property oneRespPerReq;
        @(posedge clk) disable iff (!rstn)
            respValid && !(reqValid && reqReady) |=> !respValid;
    endproperty
    oneRespPerReqA: assert property (oneRespPerReq);

endmodule

`default_nettype wire

//--- logic/cache_pkg.sv
`default_nettype none
`include "cache_config.svh"

package cache_pkg;

    // request from the pipeline, 69 bits
    typedef struct packed {
        logic [`CACHE_ADDR_W-1:0] addr;
        logic [`CACHE_DATA_W-1:0] wdata;
        logic [`CACHE_STRB_W-1:0] wstrb;
        logic                     isWrite;
    } cpuReq_t;

    // answer back to the pipeline
    typedef struct packed {
        logic [`CACHE_DATA_W-1:0] rdata;
        logic                     isWrite;   // set when this closes a store
    } cpuResp_t;

    // word request on the memory port, reads are always full word
    typedef struct packed {
        logic [`CACHE_ADDR_W-1:0] addr;
        logic [`CACHE_DATA_W-1:0] wdata;
        logic [`CACHE_STRB_W-1:0] wstrb;
        logic                     wr;        // 1 write, 0 read
    } memReq_t;

    // one cycle of array access, driven from the request buffer
    typedef struct packed {
        logic [`CACHE_INDEX_W-1:0] index;
        logic [`CACHE_TAG_W-1:0]   tag;
        logic [`CACHE_STRB_W-1:0]  wstrb;
    } lineSel_t;

endpackage

`default_nettype wire

//--- logic/dataArray.sv
`timescale 1ns/1ps
`default_nettype none
`include "cache_config.svh"

module dataArray (
    input  wire                         clk,
    input  wire cache_pkg::lineSel_t    lookup,
    input  wire [`CACHE_WAYS-1:0]       wayWe,
    input  wire                         refill,      // whole word from memory
    input  wire [`CACHE_DATA_W-1:0]     refillData,
    input  wire [`CACHE_DATA_W-1:0]     writeData,   // store data, merged by strobe
    input  wire [`CACHE_WAYS-1:0]       wayHit,
    output logic [`CACHE_DATA_W-1:0]    readWord
);

    localparam int numSets = 1 << `CACHE_INDEX_W;

    logic [`CACHE_DATA_W-1:0] dataMem [`CACHE_WAYS][numSets];

    always_ff @(posedge clk) begin
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (wayWe[w]) begin
                if (refill) begin
                    dataMem[w][lookup.index] <= refillData;
                end else begin
                    for (int b = 0; b < `CACHE_STRB_W; b++) begin
                        if (lookup.wstrb[b]) begin
                            dataMem[w][lookup.index][8*b +: 8] <= writeData[8*b +: 8];
                        end
                    end
                end
            end
        end
    end

    // word of the hitting way, zero on a miss
    always_comb begin
        readWord = '0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (wayHit[w]) begin
                readWord = dataMem[w][lookup.index];
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/l2CacheTop.sv
`timescale 1ns/1ps
`default_nettype none
`include "cache_config.svh"

module l2CacheTop (
    input  wire                         clk,
    input  wire                         rstn,

    // pipeline
    input  wire                         reqValid,
    output logic                        reqReady,
    input  wire cache_pkg::cpuReq_t     req,
    output logic                        respValid,
    output cache_pkg::cpuResp_t         resp,

    // memory
    output logic                        memReqValid,
    output cache_pkg::memReq_t          memReq,
    input  wire                         memAddrOk,
    input  wire                         memDataOk,
    input  wire [`CACHE_DATA_W-1:0]     memRdata
);

    cache_pkg::lineSel_t        lookup;
    logic [`CACHE_WAYS-1:0]     wayHit;
    logic [`CACHE_WAYS-1:0]     wayWe;
    logic [`CACHE_DATA_W-1:0]   readWord;
    logic [`CACHE_DATA_W-1:0]   refillData;
    logic                       refill;
    logic                       useValid;
    logic                       useWay;
    logic                       victimWay;

    cacheCtrlFsm ctrl (
        .clk         (clk),
        .rstn        (rstn),
        .reqValid    (reqValid),
        .reqReady    (reqReady),
        .req         (req),
        .respValid   (respValid),
        .resp        (resp),
        .memReqValid (memReqValid),
        .memReq      (memReq),
        .memAddrOk   (memAddrOk),
        .memDataOk   (memDataOk),
        .memRdata    (memRdata),
        .lookup      (lookup),
        .wayHit      (wayHit),
        .readWord    (readWord),
        .wayWe       (wayWe),
        .refill      (refill),
        .refillData  (refillData),
        .useValid    (useValid),
        .useWay      (useWay),
        .victimWay   (victimWay)
    );

    tagArray tags (
        .clk    (clk),
        .rstn   (rstn),
        .lookup (lookup),
        .wayWe  (wayWe),
        .wayHit (wayHit)
    );

    // store data is the buffered word already on the memory port
    dataArray data (
        .clk        (clk),
        .lookup     (lookup),
        .wayWe      (wayWe),
        .refill     (refill),
        .refillData (refillData),
        .writeData  (memReq.wdata),
        .wayHit     (wayHit),
        .readWord   (readWord)
    );

    lruTable lru (
        .clk       (clk),
        .rstn      (rstn),
        .lookup    (lookup),
        .useValid  (useValid),
        .useWay    (useWay),
        .victimWay (victimWay)
    );

endmodule

`default_nettype wire

//--- logic/lruTable.sv
`timescale 1ns/1ps
`default_nettype none
`include "cache_config.svh"

// one bit per set, pointing at the way to evict next
module lruTable (
    input  wire                         clk,
    input  wire                         rstn,
    input  wire cache_pkg::lineSel_t    lookup,
    input  wire                         useValid,
    input  wire                         useWay,
    output logic                        victimWay
);

    localparam int numSets = 1 << `CACHE_INDEX_W;

    logic [numSets-1:0] lruBits;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            lruBits <= '0;                          // way 0 goes first
        end else if (useValid) begin
            lruBits[lookup.index] <= ~useWay;       // the other way is now oldest
        end
    end

    assign victimWay = lruBits[lookup.index];

endmodule

`default_nettype wire

//--- logic/tagArray.sv
`timescale 1ns/1ps
`default_nettype none
`include "cache_config.svh"

module tagArray (
    input  wire                         clk,
    input  wire                         rstn,
    input  wire cache_pkg::lineSel_t    lookup,
    input  wire [`CACHE_WAYS-1:0]       wayWe,
    output logic [`CACHE_WAYS-1:0]      wayHit
);

    localparam int numSets = 1 << `CACHE_INDEX_W;

    logic [`CACHE_TAG_W-1:0]             tagMem [`CACHE_WAYS][numSets];
    logic [`CACHE_WAYS-1:0][numSets-1:0] validBits;

    //////////////////////////////////////////////////
    // storage
    //////////////////////////////////////////////////

    // all lines start empty
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            validBits <= '0;
        end else begin
            for (int w = 0; w < `CACHE_WAYS; w++) begin
                if (wayWe[w]) begin
                    validBits[w][lookup.index] <= 1'b1;
                end
            end
        end
    end

    // on a write hit the stored tag already matches, so this is a no-op
    always_ff @(posedge clk) begin
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (wayWe[w]) begin
                tagMem[w][lookup.index] <= lookup.tag;
            end
        end
    end

    //////////////////////////////////////////////////
    // compare
    //////////////////////////////////////////////////

    always_comb begin
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            wayHit[w] = validBits[w][lookup.index]
                        && (tagMem[w][lookup.index] == lookup.tag);
        end
    end

    // refill only goes to a missing line, so a tag lives in one way only
    property singleHit;
        @(posedge clk) disable iff (!rstn)
            $onehot0(wayHit);
    endproperty
    singleHitA: assert property (singleHit);

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# build and run the cache testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module cacheTb \
    -f files.f -Mdir obj_dir -o simv > build.log 2>&1 \
    && ./obj_dir/simv > sim.log 2>&1 \
    || { echo "build or run failed"; cat build.log sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -q "\*\* FAIL \*\*" sim.log && { echo "simulation failed"; exit 1; } || exit 0

//--- testbench/cacheChecker.sv
`timescale 1ns/1ps
`default_nettype none
`include "cache_config.svh"

module cacheChecker (
    input  wire                         clk,
    input  wire                         rstn,
    input  wire                         reqValid,
    input  wire                         reqReady,
    input  wire cache_pkg::cpuReq_t     req,
    input  wire                         respValid,
    input  wire cache_pkg::cpuResp_t    resp,
    input  wire                         memReqValid,
    input  wire cache_pkg::memReq_t     memReq,
    input  wire                         memAddrOk,
    input  wire [8*16-1:0]              testName,
    output int                          errCount,
    output int                          testCount
);

    int errs = 0;
    int tests = 0;
    int errAtStart = 0;
    int memReads = 0;
    int memWrites = 0;
    bit pending = 1'b0;
    bit resetChecked = 1'b0;
    bit stallSeen = 1'b0;
    cache_pkg::cpuReq_t pend;
    cache_pkg::memReq_t lastMemReq;
    cache_pkg::memReq_t memWriteSeen;

    logic [31:0] shadow [logic [31:0]];   // true memory contents by word address
    bit          tagV   [2][64];
    logic [23:0] tagT   [2][64];
    bit          lruBit [64];            // way to evict next

    assign errCount  = errs;
    assign testCount = tests;

    // untouched memory word as the memory model makes it
    function automatic logic [31:0] fillWord(input logic [31:0] addr);
        return (addr * 32'h9E37_79B1) ^ 32'h5A5A_5A5A;
    endfunction

    function automatic logic [31:0] shadowRead(input logic [31:0] addr);
        logic [31:0] key;
        key = {addr[31:2], 2'b00};
        return shadow.exists(key) ? shadow[key] : fillWord(key);
    endfunction

    task automatic checkVal(input string sig, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            errs++;
            $display("ERROR t=%0t %s expected %h got %h", $time, sig, exp, act);
        end
    endtask

    task automatic predict();
        logic [5:0]  set;
        logic [23:0] tag;
        logic [31:0] word;
        int          hitW;
        set  = pend.addr[7:2];
        tag  = pend.addr[31:8];
        hitW = -1;
        for (int w = 0; w < 2; w++) begin
            if (tagV[w][set] && tagT[w][set] == tag) hitW = w;
        end
        checkVal("resp.isWrite", {31'b0, pend.isWrite}, {31'b0, resp.isWrite});
        if (pend.isWrite) begin
            checkVal("memWrites", 1, memWrites);
            checkVal("memReads", 0, memReads);
            if (memWrites != 0) begin   // fields are only valid after a write
                checkVal("memReq.addr", pend.addr, memWriteSeen.addr);
                checkVal("memReq.wdata", pend.wdata, memWriteSeen.wdata);
                checkVal("memReq.wstrb", {28'b0, pend.wstrb}, {28'b0, memWriteSeen.wstrb});
            end
            word = shadowRead(pend.addr);
            for (int b = 0; b < 4; b++) begin
                if (pend.wstrb[b]) word[8*b +: 8] = pend.wdata[8*b +: 8];
            end
            shadow[{pend.addr[31:2], 2'b00}] = word;
            if (hitW >= 0) lruBit[set] = (hitW == 0);   // no allocate on a miss
        end else begin
            checkVal("resp.rdata", shadowRead(pend.addr), resp.rdata);
            if (hitW >= 0) begin
                checkVal("memReads", 0, memReads);
                lruBit[set] = (hitW == 0);
            end else begin
                checkVal("memReads", 1, memReads);
                tagV[lruBit[set]][set] = 1'b1;
                tagT[lruBit[set]][set] = tag;
                lruBit[set] = ~lruBit[set];
            end
            checkVal("memWrites", 0, memWrites);
        end
        tests++;
        $display("test %0d %0s: %s", tests, testName, (errs == errAtStart) ? "ok" : "FAILED");
        pending = 1'b0;
    endtask

    // sample halfway through the cycle away from the driving edge
    always @(negedge clk) begin
        if (rstn) begin
            if (!resetChecked) begin
                checkVal("reqReady", 1, {31'b0, reqReady});
                checkVal("memReqValid", 0, {31'b0, memReqValid});
                checkVal("respValid", 0, {31'b0, respValid});
                resetChecked = 1'b1;
            end

            // under back-pressure the request holds and the pipeline waits
            if (stallSeen) begin
                checkVal("memReqValid", 1, {31'b0, memReqValid});
                checkVal("memReq.addr", lastMemReq.addr, memReq.addr);
                checkVal("memReq.wdata", lastMemReq.wdata, memReq.wdata);
                checkVal("memReq.wstrb", {28'b0, lastMemReq.wstrb}, {28'b0, memReq.wstrb});
                checkVal("memReq.wr", {31'b0, lastMemReq.wr}, {31'b0, memReq.wr});
            end
            stallSeen  = memReqValid && !memAddrOk;
            lastMemReq = memReq;
            if (stallSeen) checkVal("reqReady", 0, {31'b0, reqReady});

            if (memReqValid && memAddrOk) begin
                if (memReq.wr) begin
                    memWrites++;
                    memWriteSeen = memReq;
                end else begin
                    memReads++;
                end
            end

            if (respValid) begin
                if (pending) begin
                    predict();
                end else begin
                    errs++;
                    $display("response seen at %0t with no request outstanding", $time);
                end
            end

            if (reqValid && reqReady) begin
                pending    = 1'b1;
                pend       = req;
                memReads   = 0;
                memWrites  = 0;
                errAtStart = errs;
            end
        end
    end

endmodule

`default_nettype wire

//--- testbench/cacheTb.sv
`timescale 1ns/1ps
`default_nettype none
`include "cache_config.svh"

module cacheTb;

    localparam int numTests = 24;

    logic clk;
    logic rstn;
    logic reqValid;
    logic reqReady;
    cache_pkg::cpuReq_t req;
    logic respValid;
    cache_pkg::cpuResp_t resp;
    logic memReqValid;
    cache_pkg::memReq_t memReq;
    logic memAddrOk;
    logic memDataOk;
    logic [`CACHE_DATA_W-1:0] memRdata;
    logic [8*16-1:0] curName;
    int errCount;
    int testCount;

    // stimulus table
    logic [31:0]     tAddr [numTests];
    logic            tWr   [numTests];
    logic [31:0]     tData [numTests];
    logic [3:0]      tStrb [numTests];
    logic [8*16-1:0] tName [numTests];

    logic [31:0] mem [logic [31:0]];   // memory model contents
    cache_pkg::memReq_t taken;
    int delay;

    tbClock clkGen (.clk(clk), .rstn(rstn));

    l2CacheTop uut (
        .clk(clk), .rstn(rstn),
        .reqValid(reqValid), .reqReady(reqReady), .req(req),
        .respValid(respValid), .resp(resp),
        .memReqValid(memReqValid), .memReq(memReq),
        .memAddrOk(memAddrOk), .memDataOk(memDataOk), .memRdata(memRdata)
    );

    cacheChecker respCheck (
        .clk(clk), .rstn(rstn),
        .reqValid(reqValid), .reqReady(reqReady), .req(req),
        .respValid(respValid), .resp(resp),
        .memReqValid(memReqValid), .memReq(memReq), .memAddrOk(memAddrOk),
        .testName(curName), .errCount(errCount), .testCount(testCount)
    );

    function automatic logic [31:0] fillWord(input logic [31:0] addr);
        return (addr * 32'h9E37_79B1) ^ 32'h5A5A_5A5A;
    endfunction

    task automatic setEntry(input int i, input logic [31:0] a, input logic w,
                            input logic [31:0] d, input logic [3:0] s,
                            input logic [8*16-1:0] n);
        tAddr[i] = a;
        tWr[i]   = w;
        tData[i] = d;
        tStrb[i] = s;
        tName[i] = n;
    endtask

    //////////////////////////////////////////////////
    // memory model with random addrOK and dataOK delays
    //////////////////////////////////////////////////

    initial begin
        void'($urandom(28332));
        forever begin
            @(negedge clk);
            if (memReqValid) begin
                taken = memReq;
                delay = $urandom % 4;
                repeat (delay) @(posedge clk);
                @(posedge clk);
                memAddrOk <= 1'b1;
                if (taken.wr) begin
                    if (!mem.exists(taken.addr)) mem[taken.addr] = fillWord(taken.addr);
                    for (int b = 0; b < 4; b++) begin
                        if (taken.wstrb[b]) begin
                            mem[taken.addr][8*b +: 8] = taken.wdata[8*b +: 8];
                        end
                    end
                end
                @(posedge clk);
                memAddrOk <= 1'b0;
                if (!taken.wr) begin
                    delay = $urandom % 4;
                    repeat (delay) @(posedge clk);
                    memDataOk <= 1'b1;
                    memRdata  <= mem.exists(taken.addr) ? mem[taken.addr]
                                                        : fillWord(taken.addr);
                    @(posedge clk);
                    memDataOk <= 1'b0;
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////

    initial begin
        reqValid  = 1'b0;
        req       = '0;
        memAddrOk = 1'b0;
        memDataOk = 1'b0;
        memRdata  = '0;
        curName   = "reset";

        // A, B, C share set 4
        setEntry(0,  32'h0000_0100, 0, 0,            4'h0, "rd miss");
        setEntry(1,  32'h0000_0100, 0, 0,            4'h0, "rd hit");
        setEntry(2,  32'h0000_0100, 1, 32'hDEADBEEF, 4'h3, "wr hit merge");
        setEntry(3,  32'h0000_0100, 0, 0,            4'h0, "rd merged");
        setEntry(4,  32'h4000_0200, 1, 32'h1234_5678, 4'hF, "wr miss");
        setEntry(5,  32'h4000_0200, 0, 0,            4'h0, "rd no alloc");
        setEntry(6,  32'h0000_1010, 0, 0,            4'h0, "lru rd A");
        setEntry(7,  32'h0000_2010, 0, 0,            4'h0, "lru rd B");
        setEntry(8,  32'h0000_1010, 0, 0,            4'h0, "lru rd A again");
        setEntry(9,  32'h0000_3010, 0, 0,            4'h0, "lru rd C");
        setEntry(10, 32'h0000_1010, 0, 0,            4'h0, "lru A hits");
        setEntry(11, 32'h0000_2010, 0, 0,            4'h0, "lru B misses");
        setEntry(12, 32'h4000_0204, 1, 32'hA1B2_C3D4, 4'h8, "wr miss part");
        setEntry(13, 32'h4000_0204, 0, 0,            4'h0, "rd part");
        setEntry(14, 32'h0000_0100, 0, 0,            4'h0, "rd old line");
        setEntry(15, 32'h0000_1010, 1, 32'h0055_0000, 4'h4, "wr A byte2");
        setEntry(16, 32'h0000_1010, 0, 0,            4'h0, "rd A merged");
        setEntry(17, 32'h0000_3010, 0, 0,            4'h0, "rd C");
        setEntry(18, 32'h0000_2010, 0, 0,            4'h0, "rd B");
        setEntry(19, 32'h0000_2010, 1, 32'hCAFE_F00D, 4'hF, "wr B full");
        setEntry(20, 32'h0000_2010, 0, 0,            4'h0, "rd B full");
        setEntry(21, 32'h0000_0104, 0, 0,            4'h0, "rd next miss");
        setEntry(22, 32'h0000_0104, 0, 0,            4'h0, "rd next hit");
        setEntry(23, 32'h0000_0100, 0, 0,            4'h0, "rd first");

        @(posedge rstn);
        for (int i = 0; i < numTests; i++) begin
            @(posedge clk);
            curName       <= tName[i];
            reqValid      <= 1'b1;
            req.addr      <= tAddr[i];
            req.wdata     <= tData[i];
            req.wstrb     <= tStrb[i];
            req.isWrite   <= tWr[i];
            @(negedge clk);
            while (!reqReady) @(negedge clk);
            @(posedge clk);
            reqValid <= 1'b0;
            @(negedge clk);
            while (!respValid) @(negedge clk);
        end
        repeat (3) @(posedge clk);

        $display("tests %0d of %0d, errors %0d", testCount, numTests, errCount);
        if (errCount == 0 && testCount == numTests) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // watchdog allows 20 cycles of 4 ns per table entry
    initial begin
        #(numTests * 20 * 4);
        $display("timeout, the cache stopped answering requests");
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/tbClock.sv
`timescale 1ns/1ps
`default_nettype none

// 4 ns clock, reset held low for the first 3 cycles
module tbClock (
    output logic clk,
    output logic rstn
);

    initial clk = 1'b0;
    always #2 clk = ~clk;

    initial begin
        rstn = 1'b0;
        repeat (3) @(posedge clk);
        rstn <= 1'b1;
    end

endmodule

`default_nettype wire
